// File: source/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // ====================
    // Stream widths
    // ====================
    localparam int word_width     = 32;
    localparam int byte_width     = 8;
    localparam int bytes_per_word = word_width / byte_width;
    localparam int count_width    = 16;  // Byte counters and segment lengths.

    // ====================
    // Byte lane
    // ====================
    // One file byte plus the end-of-file flag.
    typedef struct packed {
        logic [byte_width-1:0] data;
        logic                  last;
    } byte_lane_t;

endpackage

`default_nettype wire

// File: source/jpeg_pkg.sv
`default_nettype none

package jpeg_pkg;

    // ====================
    // Marker codes
    // ====================
    localparam logic [7:0] marker_prefix = 8'hFF;
    localparam logic [7:0] soi           = 8'hD8;
    localparam logic [7:0] eoi           = 8'hD9;
    localparam logic [7:0] sof0          = 8'hC0;  // Baseline frame.
    localparam logic [7:0] dht           = 8'hC4;
    localparam logic [7:0] dqt           = 8'hDB;
    localparam logic [7:0] sos           = 8'hDA;
    localparam logic [7:0] rst_first     = 8'hD0;
    localparam logic [7:0] rst_last      = 8'hD7;

    // ====================
    // Parser types
    // ====================
    typedef enum logic [2:0] {
        idle,          // Expecting the FF of a marker.
        marker,
        length_hi,
        length_lo,
        segment_body,
        scan,
        done
    } parser_state_t;

    typedef struct packed {
        logic [15:0] height;
        logic [15:0] width;
        logic [7:0]  components;
        logic [3:0]  quant_tables;
        logic [3:0]  huff_tables;
        logic        format_error;
        logic        valid;   // Set once SOS is seen.
        logic [1:0]  padding;
    } frame_info_t;

endpackage

`default_nettype wire

// File: source/byte_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

// One byte per transfer. A transfer happens when valid is high and stall is low.
interface byte_stream_if;
    import stream_pkg::*;

    byte_lane_t lane;
    logic       valid;
    logic       stall;

    modport source (
        output lane,
        output valid,
        input  stall
    );

    modport sink (
        input  lane,
        input  valid,
        output stall
    );

endinterface

`default_nettype wire

// File: source/stream_unpacker.sv
`timescale 1ns/100ps
`default_nettype none

module stream_unpacker (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [stream_pkg::word_width-1:0] in_data,
    input  logic                              in_valid,
    output logic                              upstream_stall,
    byte_stream_if.source                     bytes
);
    import stream_pkg::*;

    logic [word_width-1:0]             word_reg;
    logic [$clog2(bytes_per_word)-1:0] byte_idx;
    logic                              word_full;
    logic                              have_length;
    logic                              finished;
    logic [count_width-1:0]            byte_total;
    logic [count_width-1:0]            byte_count;  // Bytes sent so far.
    logic                              byte_xfer;
    logic                              is_last;
    logic                              take_word;
    logic                              word_accept;

    assign is_last   = (byte_count + count_width'(1)) == byte_total;
    assign byte_xfer = word_full && !bytes.stall;

    // Register is free, or its top byte leaves this cycle.
    assign take_word = !finished &&
                       (!have_length || !word_full || (byte_xfer && &byte_idx && !is_last));
    assign upstream_stall = !take_word;
    assign word_accept    = take_word && in_valid;

    assign bytes.lane.data = word_reg[byte_width-1:0];
    assign bytes.lane.last = is_last;
    assign bytes.valid     = word_full;

    always_ff @(posedge clock) begin
        if (reset) begin
            have_length <= 1'b0;
            finished    <= 1'b0;
            word_full   <= 1'b0;
            byte_idx    <= '0;
            byte_count  <= '0;
            byte_total  <= '0;
        end else begin
            if (byte_xfer) begin
                word_reg   <= word_reg >> byte_width;
                byte_idx   <= byte_idx + 1'b1;
                byte_count <= byte_count + 1'b1;
                if (is_last) begin
                    finished  <= 1'b1;  // Padding bytes are dropped.
                    word_full <= 1'b0;
                end else if (&byte_idx) begin
                    word_full <= 1'b0;
                end
            end
            if (word_accept) begin
                if (!have_length) begin
                    byte_total  <= in_data[count_width-1:0];
                    have_length <= 1'b1;
                end else begin
                    word_reg  <= in_data;
                    word_full <= 1'b1;
                    byte_idx  <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/marker_parser.sv
`timescale 1ns/100ps
`default_nettype none

module marker_parser (
    input  logic                  clock,
    input  logic                  reset,
    byte_stream_if.sink           bytes_in,
    byte_stream_if.source         bytes_out,
    output logic                  scan_data,
    output jpeg_pkg::frame_info_t frame_info
);
    import stream_pkg::*;
    import jpeg_pkg::*;

    parser_state_t          state;
    byte_lane_t             held;
    logic                   held_valid;
    logic                   held_scan;   // Arrived in the scan state.
    logic [byte_width-1:0]  in_byte;
    logic [byte_width-1:0]  cur_marker;
    logic [byte_width-1:0]  len_hi;
    logic [count_width-1:0] seg_remain;
    logic [count_width-1:0] seg_length;
    logic [2:0]             body_idx;
    logic                   first_marker_seen;
    logic                   in_xfer;
    logic                   prev_ff;
    logic                   next_nonzero;

    assign in_byte    = bytes_in.lane.data;
    assign seg_length = {len_hi, in_byte};
    assign in_xfer    = bytes_in.valid && !bytes_out.stall;
    assign prev_ff    = held_valid && held.data == marker_prefix;

    // Shared input bus, so this stage also returns the stall for the destuffer.
    assign bytes_in.stall = bytes_out.stall;

    // ====================
    // Hold stage
    // ====================
    // A byte leaves only once its successor is present.
    assign bytes_out.lane  = held;
    assign bytes_out.valid = held_valid && (bytes_in.valid || held.last);

    assign next_nonzero = !bytes_in.valid || in_byte != '0;
    assign scan_data    = bytes_out.valid && held_scan &&
                          !(held.data == marker_prefix && next_nonzero);

    always_ff @(posedge clock) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (in_xfer) begin
            held_valid <= 1'b1;
        end else if (bytes_out.valid && !bytes_out.stall) begin
            held_valid <= 1'b0;  // Final byte drains.
        end
    end

    always_ff @(posedge clock) begin
        if (in_xfer) begin
            held      <= bytes_in.lane;
            held_scan <= (state == scan) && !prev_ff;
        end
    end

    // ====================
    // Segment FSM
    // ====================
    always_ff @(posedge clock) begin
        if (reset) begin
            state             <= idle;
            frame_info        <= '0;
            first_marker_seen <= 1'b0;
            cur_marker        <= '0;
            len_hi            <= '0;
            seg_remain        <= '0;
            body_idx          <= '0;
        end else if (in_xfer) begin
            case (state)
                idle: begin
                    if (in_byte == marker_prefix) begin
                        state <= marker;
                    end else if (!first_marker_seen) begin
                        frame_info.format_error <= 1'b1;
                    end
                end
                marker: begin
                    if (in_byte != marker_prefix) begin  // FF here is fill.
                        cur_marker        <= in_byte;
                        first_marker_seen <= 1'b1;
                        if (!first_marker_seen && in_byte != soi) begin
                            frame_info.format_error <= 1'b1;
                        end
                        if (in_byte == eoi) begin
                            state <= done;
                        end else if (in_byte == soi ||
                                     (in_byte >= rst_first && in_byte <= rst_last)) begin
                            state <= idle;
                        end else begin
                            state <= length_hi;
                        end
                        if (in_byte == dqt) begin
                            frame_info.quant_tables <= frame_info.quant_tables + 1'b1;
                        end
                        if (in_byte == dht) begin
                            frame_info.huff_tables <= frame_info.huff_tables + 1'b1;
                        end
                        if (in_byte == sos) begin
                            frame_info.valid <= 1'b1;
                        end
                    end
                end
                length_hi: begin
                    len_hi <= in_byte;
                    state  <= length_lo;
                end
                length_lo: begin
                    seg_remain <= seg_length - count_width'(2);  // Length counts itself.
                    body_idx   <= '0;
                    if (seg_length <= count_width'(2)) begin
                        state <= (cur_marker == sos) ? scan : idle;
                    end else begin
                        state <= segment_body;
                    end
                end
                segment_body: begin
                    seg_remain <= seg_remain - 1'b1;
                    if (body_idx != '1) begin
                        body_idx <= body_idx + 1'b1;
                    end
                    if (cur_marker == sof0) begin
                        case (body_idx)
                            3'd1:    frame_info.height[15:8]  <= in_byte;
                            3'd2:    frame_info.height[7:0]   <= in_byte;
                            3'd3:    frame_info.width[15:8]   <= in_byte;
                            3'd4:    frame_info.width[7:0]    <= in_byte;
                            3'd5:    frame_info.components    <= in_byte;
                            default: ;
                        endcase
                    end
                    if (seg_remain == count_width'(1)) begin
                        state <= (cur_marker == sos) ? scan : idle;
                    end
                end
                scan: begin
                    if (prev_ff && in_byte == eoi) begin
                        state <= done;
                    end
                end
                default: ;  // Done until reset.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/scan_destuffer.sv
`timescale 1ns/100ps
`default_nettype none

module scan_destuffer (
    input  logic          clock,
    input  logic          reset,
    byte_stream_if.sink   bytes_in,
    byte_stream_if.source bytes_out
);
    import stream_pkg::*;
    import jpeg_pkg::*;

    byte_lane_t held;
    logic       held_valid;
    logic       held_drop;  // Stuffed 00.
    logic       in_xfer;
    logic       ready_out;

    // Stall on the shared input bus comes from the parser.
    assign in_xfer   = bytes_in.valid && !bytes_out.stall;
    assign ready_out = held_valid && (bytes_in.valid || held.last);

    assign bytes_out.lane  = held;
    assign bytes_out.valid = ready_out && !held_drop;

    always_ff @(posedge clock) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (in_xfer) begin
            held_valid <= 1'b1;
        end else if (ready_out && !bytes_out.stall) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (in_xfer) begin
            held      <= bytes_in.lane;
            held_drop <= held_valid && held.data == marker_prefix &&
                         bytes_in.lane.data == '0;
        end
    end

endmodule

`default_nettype wire

// File: source/output_packer.sv
`timescale 1ns/100ps
`default_nettype none

module output_packer (
    input  logic                              clock,
    input  logic                              reset,
    byte_stream_if.sink                       scan_bytes,
    byte_stream_if.sink                       parse_bytes,
    input  logic                              scan_data,
    input  jpeg_pkg::frame_info_t             frame_info,
    output logic [stream_pkg::word_width-1:0] out_data,
    output logic                              out_valid,
    input  logic                              downstream_stall
);
    import stream_pkg::*;

    logic [word_width-1:0]             acc;
    logic [word_width-1:0]             acc_next;
    logic [word_width-1:0]             trailer;
    logic [$clog2(bytes_per_word)-1:0] acc_cnt;
    logic [count_width-1:0]            kept_count;
    logic                              info_sent;
    logic                              trailer_pend;
    logic                              finished;
    logic                              info_pend;
    logic                              out_free;
    logic                              stall_br;
    logic                              step;
    logic                              keep;
    logic                              word_done;
    logic                              flush;
    logic                              load_data;

    assign info_pend = frame_info.valid && !frame_info.format_error && !info_sent;
    assign out_free  = !(out_valid && downstream_stall);

    // One stall for both branches keeps them aligned.
    assign stall_br          = info_pend || trailer_pend || finished || !out_free;
    assign scan_bytes.stall  = stall_br;
    assign parse_bytes.stall = stall_br;

    assign step      = parse_bytes.valid && !stall_br;
    assign keep      = step && scan_data && scan_bytes.valid;
    assign word_done = keep && &acc_cnt;
    assign flush     = step && parse_bytes.lane.last && (acc_cnt != '0 || keep);
    assign load_data = word_done || flush;

    assign trailer = {frame_info.huff_tables, frame_info.quant_tables, frame_info.components,
                      kept_count[count_width-1] | frame_info.format_error,
                      kept_count[count_width-2:0]};

    always_comb begin
        acc_next = acc;
        if (keep) begin
            acc_next[acc_cnt*byte_width +: byte_width] = scan_bytes.lane.data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid    <= 1'b0;
            info_sent    <= 1'b0;
            trailer_pend <= 1'b0;
            finished     <= 1'b0;
            acc          <= '0;
            acc_cnt      <= '0;
            kept_count   <= '0;
        end else begin
            if (!downstream_stall) begin
                out_valid <= 1'b0;
            end
            if (info_pend && out_free) begin
                out_data  <= {frame_info.height, frame_info.width};
                out_valid <= 1'b1;
                info_sent <= 1'b1;
            end else if (trailer_pend && out_free) begin
                out_data     <= trailer;
                out_valid    <= 1'b1;
                trailer_pend <= 1'b0;
                finished     <= 1'b1;
            end else if (load_data) begin
                out_data  <= acc_next;
                out_valid <= 1'b1;
            end
            if (load_data) begin
                acc     <= '0;  // Zero pad for the flush.
                acc_cnt <= '0;
            end else begin
                acc <= acc_next;
                if (keep) begin
                    acc_cnt <= acc_cnt + 1'b1;
                end
            end
            if (keep) begin
                kept_count <= kept_count + 1'b1;
            end
            if (step && parse_bytes.lane.last) begin
                trailer_pend <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/img_preproc_top.sv
`timescale 1ns/100ps
`default_nettype none

module img_preproc_top (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [stream_pkg::word_width-1:0] in_data,
    input  logic                              in_valid,
    output logic                              upstream_stall,
    output logic [stream_pkg::word_width-1:0] out_data,
    output logic                              out_valid,
    input  logic                              downstream_stall
);
    import jpeg_pkg::*;

    frame_info_t frame_info;
    logic        scan_data;

    byte_stream_if raw_bus ();    // Feeds both branches.
    byte_stream_if parse_bus ();
    byte_stream_if scan_bus ();

    stream_unpacker unpacker (
        .clock          (clock),
        .reset          (reset),
        .in_data        (in_data),
        .in_valid       (in_valid),
        .upstream_stall (upstream_stall),
        .bytes          (raw_bus.source)
    );

    marker_parser parser (
        .clock      (clock),
        .reset      (reset),
        .bytes_in   (raw_bus.sink),
        .bytes_out  (parse_bus.source),
        .scan_data  (scan_data),
        .frame_info (frame_info)
    );

    scan_destuffer destuffer (
        .clock     (clock),
        .reset     (reset),
        .bytes_in  (raw_bus.sink),
        .bytes_out (scan_bus.source)
    );

    output_packer packer (
        .clock            (clock),
        .reset            (reset),
        .scan_bytes       (scan_bus.sink),
        .parse_bytes      (parse_bus.sink),
        .scan_data        (scan_data),
        .frame_info       (frame_info),
        .out_data         (out_data),
        .out_valid        (out_valid),
        .downstream_stall (downstream_stall)
    );

endmodule

`default_nettype wire

// File: tests/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);
    localparam int half_period  = 10;  // 20 ns clock.
    localparam int reset_cycles = 2;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #2 reset = 1'b0;  // Same offset as the other inputs.
    end

endmodule

`default_nettype wire

// File: tests/img_preproc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module img_preproc_tb;
    import stream_pkg::*;

    localparam string stimulus_path = "tests/img_stimulus.txt";
    localparam int    drive_delay   = 2;  // ns after the rising edge.

    logic                  clock;
    logic                  power_reset;
    logic                  file_reset;
    logic                  reset;
    logic [word_width-1:0] in_data;
    logic                  in_valid;
    logic                  upstream_stall;
    logic [word_width-1:0] out_data;
    logic                  out_valid;
    logic                  downstream_stall;

    logic [word_width-1:0] in_words[$];
    logic [word_width-1:0] exp_words[$];
    int                    file_in_count[$];
    int                    file_exp_count[$];
    int                    exp_next    = 0;
    int                    exp_limit   = 0;
    int                    file_idx    = 0;
    int                    errors      = 0;
    int                    checked     = 0;
    int                    cycles      = 0;
    int                    cycle_limit = 0;
    bit                    read_ok;

    clock_gen clocks (
        .clock (clock),
        .reset (power_reset)
    );

    assign reset = power_reset || file_reset;

    img_preproc_top UUT (
        .clock            (clock),
        .reset            (reset),
        .in_data          (in_data),
        .in_valid         (in_valid),
        .upstream_stall   (upstream_stall),
        .out_data         (out_data),
        .out_valid        (out_valid),
        .downstream_stall (downstream_stall)
    );

    // ====================
    // Stimulus file
    // ====================
    task automatic read_stimulus();
        int                    fd;
        int                    fields;
        int                    in_run;
        int                    exp_run;
        bit                    at_end;
        string                 line;
        logic [7:0]            tag;
        logic [word_width-1:0] value;
        fd      = $fopen(stimulus_path, "r");
        read_ok = (fd != 0);
        in_run  = 0;
        exp_run = 0;
        at_end  = !read_ok;
        while (!at_end) begin
            line   = "";
            at_end = ($fgets(line, fd) == 0);
            tag    = 8'h00;
            fields = $sscanf(line, "%c %h", tag, value);
            if (fields == 2 && tag == "I") begin
                in_words.push_back(value);
                in_run++;
            end else if (fields == 2 && tag == "O") begin
                exp_words.push_back(value);
                exp_run++;
            end else if (tag != "#" && in_run > 0) begin
                // Blank line or end of file closes one test file.
                file_in_count.push_back(in_run);
                file_exp_count.push_back(exp_run);
                in_run  = 0;
                exp_run = 0;
            end
        end
        if (read_ok) begin
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        #drive_delay;
        file_reset = 1'b1;
        repeat (2) @(posedge clock);
        #drive_delay;
        file_reset = 1'b0;
    endtask

    // Feeds one file word by word, then waits for all its output words.
    task automatic run_file(input int in_base, input int in_count, input int exp_count);
        int idx;
        bit accepted;
        exp_limit = exp_next + exp_count;
        idx       = 0;
        // Just out of reset the unpacker takes a word and nothing is on the output.
        assert (!upstream_stall && !out_valid) else begin
            errors++;
            $display("upstream_stall or out_valid is high right after reset in file %0d",
                     file_idx);
        end
        while (idx < in_count) begin
            in_data  = in_words[in_base + idx];
            in_valid = 1'b1;
            @(negedge clock);
            accepted = !upstream_stall;
            @(posedge clock);
            #drive_delay;
            if (accepted) begin
                idx++;
            end
        end
        in_valid = 1'b0;
        in_data  = '0;
        while (exp_next < exp_limit) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);  // Room for a stray extra word.
    endtask

    // ====================
    // Output checker
    // ====================
    always @(negedge clock) begin
        if (!reset && out_valid && !downstream_stall) begin
            assert (exp_next < exp_limit) else begin
                errors++;
                $display("Output word %h came after all expected words of file %0d",
                         out_data, file_idx);
            end
            if (exp_next < exp_limit) begin
                assert (out_data == exp_words[exp_next]) else begin
                    errors++;
                    $display("[FAIL] %0t: file %0d, expected word %0d is %h, expected %h",
                             $time, file_idx, exp_next, out_data, exp_words[exp_next]);
                end
                checked++;
                exp_next++;
            end
        end
    end

    // Random back-pressure on the output.
    initial begin
        downstream_stall = 1'b0;
        void'($urandom(32'hd829_32d7));
        forever begin
            @(posedge clock);
            #drive_delay;
            downstream_stall = ($urandom % 4) == 0;
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("%0d output words checked, %0d errors", checked, errors);
        $display("TESTS FAILED");
        $finish;
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        int in_base;
        int total_bytes;
        in_data    = '0;
        in_valid   = 1'b0;
        file_reset = 1'b0;
        read_stimulus();
        if (!read_ok || file_in_count.size() == 0) begin
            $display("Could not read any test file from %s", stimulus_path);
            $display("TESTS FAILED");
            $finish;
        end else begin
            in_base     = 0;
            total_bytes = 0;
            foreach (file_in_count[f]) begin
                total_bytes += int'(in_words[in_base][count_width-1:0]);  // Length word.
                in_base     += file_in_count[f];
            end
            cycle_limit = 40 * total_bytes + 200;
            @(negedge power_reset);
            in_base = 0;
            foreach (file_in_count[f]) begin
                if (f > 0) begin
                    apply_reset();
                end
                file_idx = f;
                run_file(in_base, file_in_count[f], file_exp_count[f]);
                in_base += file_in_count[f];
            end
            $display("%0d output words checked, %0d errors", checked, errors);
            if (errors == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/img_stimulus.txt
# Columns: tag and 32-bit hex word. Tag I is an input word, tag O an expected output word.
# The first I word of a file is its byte length. A blank line ends one test file.
# SOI, DQT, DHT, SOF0 16x24, SOS, scan with a stuffed FF 00 and RST0, EOI.
I 00000026
I DBFFD8FF
I FF110300
I 220300C4
I 0800C0FF
I 00100008
I DAFF0318
I 12010300
I 5600FF34
I 9A78D0FF
I A5A5D9FF
O 00100018
O 56FF3412
O 00009A78
O 11030006

# File opens with DQT instead of SOI, so no info word and the error bit.
I 0000001A
I 0300DBFF
I 00C0FF11
I 20000808
I FF014000
I AB0200DA
I EFCD00FF
I 5A5AD9FF
O EFCDFFAB
O 01018004

// File: sources.f
source/stream_pkg.sv
source/jpeg_pkg.sv
source/byte_stream_if.sv
source/stream_unpacker.sv
source/marker_parser.sv
source/scan_destuffer.sv
source/output_packer.sv
source/img_preproc_top.sv
tests/clock_gen.sv
tests/img_preproc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module img_preproc_tb -f sources.f -o img_preproc_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/img_preproc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
